//--- logic/psCfgPkg.sv
// ----------------------------------------------------------
// Power-supply configuration shared definitions
// Host command codes, flash operation kind and the tick
// counter width used by the UFM sequencer
// ----------------------------------------------------------
`default_nettype none

package psCfgPkg;

    // ----------------------------------------------------------
    // Host command byte
    // ----------------------------------------------------------
    typedef logic [7:0] cmdByte_t;

    // Read back the stored mode bit
    localparam cmdByte_t CmdReadCfg = 8'hB0;

    // Upper seven bits of a write command
    // Bit 0 of the byte holds the inverted mode bit
    localparam logic [6:0] CmdWriteCfgPrefix = 7'h50;

    // ----------------------------------------------------------
    // Flash operation kind
    // ----------------------------------------------------------
    typedef enum logic {
        OpRead  = 1'b0,
        OpWrite = 1'b1
    } opKind_t;

    // ----------------------------------------------------------
    // Tick counter
    // ----------------------------------------------------------
    // Production write runs past 1000 ticks, so 16 bits
    typedef logic [15:0] tickCount_t;

endpackage

`default_nettype wire

//--- logic/psCmdMonitor.sv
// ----------------------------------------------------------
// Host command monitor
// Watches the host command byte on each 1 ms tick and turns
// a changed read or write code into a flash request
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psCmdMonitor
    import psCfgPkg::*;
(
    input  logic     CLK32768,
    input  logic     ResetN,
    input  logic     tick_i,
    input  cmdByte_t cmd_i,
    input  logic     promBusy_i,
    input  logic     reqAck_i,
    output logic     reqValid_o,
    output opKind_t  reqKind_o,
    output logic     reqBit_o
);

    // Last command byte acted on
    cmdByte_t lastCmd;

    logic pending;
    logic isRead;
    logic isWrite;
    logic sample;
    logic issue;

    // Handshake still open on either phase
    assign pending = reqValid_o | reqAck_i;

    // Command decode
    assign isRead  = (cmd_i == CmdReadCfg);
    assign isWrite = (cmd_i[7:1] == CmdWriteCfgPrefix);

    // Only a changed byte counts, and only when nothing is in flight
    assign sample = tick_i & ~pending & ~promBusy_i & (cmd_i != lastCmd);
    // Unknown bytes only refresh the stored copy
    assign issue  = sample & (isRead | isWrite);

    // ----------------------------------------------------------
    // Request handshake and stored command
    // ----------------------------------------------------------
    always_ff @(posedge CLK32768 or negedge ResetN) begin
        if (!ResetN) begin
            lastCmd    <= '0;
            reqValid_o <= 1'b0;
        end else if (tick_i) begin
            // Holder has the payload, release the request
            if (reqValid_o && reqAck_i) begin
                reqValid_o <= 1'b0;
            end else if (issue) begin
                reqValid_o <= 1'b1;
            end
            if (sample) begin
                lastCmd <= cmd_i;
            end
        end
    end

    // Payload stays stable while the request is up
    always_ff @(posedge CLK32768) begin
        if (issue) begin
            reqKind_o <= isWrite ? OpWrite : OpRead;
            // Write carries the inverse of bit 0
            reqBit_o  <= ~cmd_i[0];
        end
    end

endmodule

`default_nettype wire

//--- logic/psReqHolder.sv
// ----------------------------------------------------------
// One-entry request holder
// Takes a request from the command monitor and offers it to
// the flash sequencer, one handshake on each side
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psReqHolder
    import psCfgPkg::*;
(
    input  logic    CLK32768,
    input  logic    ResetN,
    input  logic    reqValid_i,
    input  opKind_t reqKind_i,
    input  logic    reqBit_i,
    input  logic    opAck_i,
    output logic    reqAck_o,
    output logic    opValid_o,
    output opKind_t opKind_o,
    output logic    opBit_o
);

    logic full;
    logic accept;
    logic take;

    // Store only when empty and the previous ack is gone
    assign accept = reqValid_i & ~reqAck_o & ~full;
    // Sequencer has started the operation
    assign take   = opValid_o & opAck_i;

    always_ff @(posedge CLK32768 or negedge ResetN) begin
        if (!ResetN) begin
            full      <= 1'b0;
            reqAck_o  <= 1'b0;
            opValid_o <= 1'b0;
        end else begin
            // Monitor side
            if (accept) begin
                reqAck_o <= 1'b1;
            end else if (reqAck_o && !reqValid_i) begin
                reqAck_o <= 1'b0;
            end

            // Entry state
            if (accept) begin
                full <= 1'b1;
            end else if (take) begin
                full <= 1'b0;
            end

            // Sequencer side, wait for the old ack to drop first
            if (take) begin
                opValid_o <= 1'b0;
            end else if (full && !opValid_o && !opAck_i) begin
                opValid_o <= 1'b1;
            end
        end
    end

    // Stored request
    always_ff @(posedge CLK32768) begin
        if (accept) begin
            opKind_o <= reqKind_i;
            opBit_o  <= reqBit_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/psPromSequencer.sv
// ----------------------------------------------------------
// UFM flash sequencer
// Runs the tick-paced write or read sequence on the flash
// request and pulse lines, and drives the configuration bit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psPromSequencer
    import psCfgPkg::*;
#(
    // Write sequence, in ticks after the request rises
    parameter tickCount_t WrStart = 16'd2,
    parameter tickCount_t WrEnd   = 16'd6,
    parameter tickCount_t RbStart = 16'd8,
    parameter tickCount_t RbEnd   = 16'd9,
    parameter tickCount_t WrDone  = 16'd11,
    // Read sequence
    parameter tickCount_t RdStart = 16'd2,
    parameter tickCount_t RdEnd   = 16'd4,
    parameter tickCount_t RdDone  = 16'd6
) (
    input  logic    CLK32768,
    input  logic    ResetN,
    input  logic    tick_i,
    input  logic    opValid_i,
    input  opKind_t opKind_i,
    input  logic    opBit_i,
    input  logic    cfgRdBit_i,
    output logic    opAck_o,
    output logic    promReq_o,
    output logic    rdPulse_o,
    output logic    wrPulse_o,
    output logic    cfgBit_o
);

    typedef enum logic [1:0] {
        SeqIdle  = 2'd0,
        SeqWrite = 2'd1,
        SeqRead  = 2'd2
    } seqState_t;

    seqState_t  state;
    // Number of the coming tick within the sequence
    tickCount_t tickCnt;

    // ----------------------------------------------------------
    // Sequence FSM
    // ----------------------------------------------------------
    always_ff @(posedge CLK32768 or negedge ResetN) begin
        if (!ResetN) begin
            state     <= SeqIdle;
            tickCnt   <= '0;
            opAck_o   <= 1'b0;
            promReq_o <= 1'b0;
            rdPulse_o <= 1'b0;
            wrPulse_o <= 1'b0;
            cfgBit_o  <= 1'b0;
        end else if (tick_i) begin
            // Close the handshake once the holder has let go
            if (opAck_o && !opValid_i) begin
                opAck_o <= 1'b0;
            end

            case (state)
                SeqIdle: begin
                    cfgBit_o <= cfgRdBit_i;
                    // Tick 0 of a new operation
                    if (opValid_i && !opAck_o) begin
                        opAck_o   <= 1'b1;
                        promReq_o <= 1'b1;
                        tickCnt   <= 16'd1;
                        if (opKind_i == OpWrite) begin
                            state    <= SeqWrite;
                            // Bit under write shows on the output at once
                            cfgBit_o <= opBit_i;
                        end else begin
                            state <= SeqRead;
                        end
                    end
                end

                SeqWrite: begin
                    tickCnt <= tickCnt + 16'd1;
                    // Program pulse
                    if (tickCnt == WrStart) wrPulse_o <= 1'b1;
                    if (tickCnt == WrEnd)   wrPulse_o <= 1'b0;
                    // Read-back pulse
                    if (tickCnt == RbStart) rdPulse_o <= 1'b1;
                    if (tickCnt == RbEnd)   rdPulse_o <= 1'b0;
                    if (tickCnt == WrDone) begin
                        promReq_o <= 1'b0;
                        wrPulse_o <= 1'b0;
                        rdPulse_o <= 1'b0;
                        cfgBit_o  <= cfgRdBit_i;
                        state     <= SeqIdle;
                    end
                end

                SeqRead: begin
                    tickCnt  <= tickCnt + 16'd1;
                    // Flash value passes through during a read
                    cfgBit_o <= cfgRdBit_i;
                    if (tickCnt == RdStart) rdPulse_o <= 1'b1;
                    if (tickCnt == RdEnd)   rdPulse_o <= 1'b0;
                    if (tickCnt == RdDone) begin
                        promReq_o <= 1'b0;
                        rdPulse_o <= 1'b0;
                        state     <= SeqIdle;
                    end
                end

                default: begin
                    state <= SeqIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/psCfgTop.sv
// ----------------------------------------------------------
// Power-supply configuration top level
// Command monitor, request holder and flash sequencer,
// with the sequence timing set here
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psCfgTop
    import psCfgPkg::*;
#(
    // Short defaults for simulation
    // Production uses 32, 1047, 1063, 1079, 1095 and 32, 48, 100
    parameter tickCount_t WrStart = 16'd2,
    parameter tickCount_t WrEnd   = 16'd6,
    parameter tickCount_t RbStart = 16'd8,
    parameter tickCount_t RbEnd   = 16'd9,
    parameter tickCount_t WrDone  = 16'd11,
    parameter tickCount_t RdStart = 16'd2,
    parameter tickCount_t RdEnd   = 16'd4,
    parameter tickCount_t RdDone  = 16'd6
) (
    input  logic     CLK32768,
    input  logic     ResetN,
    input  logic     tick_i,
    input  cmdByte_t cmd_i,
    input  logic     promBusy_i,
    input  logic     cfgRdBit_i,
    output logic     promReq_o,
    output logic     rdPulse_o,
    output logic     wrPulse_o,
    output logic     cfgBit_o
);

    // Monitor to holder
    logic    reqValid;
    logic    reqAck;
    opKind_t reqKind;
    logic    reqBit;

    // Holder to sequencer
    logic    opValid;
    logic    opAck;
    opKind_t opKind;
    logic    opBit;

    psCmdMonitor psCmdMonitor_i (
        .CLK32768   (CLK32768),
        .ResetN     (ResetN),
        .tick_i     (tick_i),
        .cmd_i      (cmd_i),
        .promBusy_i (promBusy_i),
        .reqAck_i   (reqAck),
        .reqValid_o (reqValid),
        .reqKind_o  (reqKind),
        .reqBit_o   (reqBit)
    );

    psReqHolder psReqHolder_i (
        .CLK32768   (CLK32768),
        .ResetN     (ResetN),
        .reqValid_i (reqValid),
        .reqKind_i  (reqKind),
        .reqBit_i   (reqBit),
        .opAck_i    (opAck),
        .reqAck_o   (reqAck),
        .opValid_o  (opValid),
        .opKind_o   (opKind),
        .opBit_o    (opBit)
    );

    psPromSequencer #(
        .WrStart (WrStart),
        .WrEnd   (WrEnd),
        .RbStart (RbStart),
        .RbEnd   (RbEnd),
        .WrDone  (WrDone),
        .RdStart (RdStart),
        .RdEnd   (RdEnd),
        .RdDone  (RdDone)
    ) psPromSequencer_i (
        .CLK32768   (CLK32768),
        .ResetN     (ResetN),
        .tick_i     (tick_i),
        .opValid_i  (opValid),
        .opKind_i   (opKind),
        .opBit_i    (opBit),
        .cfgRdBit_i (cfgRdBit_i),
        .opAck_o    (opAck),
        .promReq_o  (promReq_o),
        .rdPulse_o  (rdPulse_o),
        .wrPulse_o  (wrPulse_o),
        .cfgBit_o   (cfgBit_o)
    );

endmodule

`default_nettype wire

//--- tests/psCfgTop_chk.sv
// ----------------------------------------------------------
// Bound assertions on the configuration top level
// Pulse exclusivity, pulses only under the flash request,
// and quiet outputs through and just after reset
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psCfgTop_chk (
    input logic CLK32768,
    input logic ResetN,
    input logic promReq_i,
    input logic rdPulse_i,
    input logic wrPulse_i,
    input logic cfgBit_i
);

    // Failure counts, summed for the testbench
    int bothFails;
    int bareFails;
    int resetFails;
    int failCount;

    assign failCount = bothFails + bareFails + resetFails;

    pulsesExclusive: assert property (@(posedge CLK32768) disable iff (!ResetN)
        !(wrPulse_i && rdPulse_i))
        else begin
            $error("Write and read pulses high together");
            bothFails++;
        end

    // A pulse only inside a flash request
    pulseUnderReq: assert property (@(posedge CLK32768) disable iff (!ResetN)
        (wrPulse_i || rdPulse_i) |-> promReq_i)
        else begin
            $error("Flash pulse high without a flash request");
            bareFails++;
        end

    quietAtReset: assert property (@(posedge CLK32768)
        (!ResetN || $rose(ResetN)) |-> !(promReq_i || rdPulse_i || wrPulse_i || cfgBit_i))
        else begin
            $error("Output high during or right after reset");
            resetFails++;
        end

endmodule

bind psCfgTop psCfgTop_chk psCfgTop_chk_i (
    .CLK32768  (CLK32768),
    .ResetN    (ResetN),
    .promReq_i (promReq_o),
    .rdPulse_i (rdPulse_o),
    .wrPulse_i (wrPulse_o),
    .cfgBit_i  (cfgBit_o)
);

`default_nettype wire

//--- tests/psCfgChk.sv
// ----------------------------------------------------------
// Checker for the power-supply configuration block
// Models the command monitor and the tick-numbered flash
// sequence, compares the DUT outputs after every tick
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psCfgChk
    import psCfgPkg::*;
#(
    parameter int WrStart = 2,
    parameter int WrEnd   = 6,
    parameter int RbStart = 8,
    parameter int RbEnd   = 9,
    parameter int WrDone  = 11,
    parameter int RdStart = 2,
    parameter int RdEnd   = 4,
    parameter int RdDone  = 6
) (
    input  logic     CLK32768,
    input  logic     ResetN,
    input  logic     tick_i,
    input  cmdByte_t cmd_i,
    input  logic     promBusy_i,
    input  logic     cfgRdBit_i,
    input  logic     promReq_i,
    input  logic     rdPulse_i,
    input  logic     wrPulse_i,
    input  logic     cfgBit_i,
    input  int       testNo_i,
    output int       errCount_o,
    output int       testsFailed_o,
    output int       opsSeen_o
);

    // Inputs as seen by the DUT on the latest tick
    cmdByte_t smpCmd;
    logic     smpBusy;
    logic     smpRdBit;
    logic     due;

    // Monitor model
    cmdByte_t lastActed;
    logic     opPend;
    opKind_t  pendKind;
    logic     pendBit;
    int       pendAge;

    // Sequence model, n is the tick number since the request rose
    logic     running;
    opKind_t  runKind;
    logic     runBit;
    int       n;

    int       curTest;
    int       testErrs;
    cmdByte_t testCmd;

    task automatic compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b (test %0d, tick %0d)",
                     $time, name, got, exp, curTest, n);
            errCount_o++;
            testErrs++;
        end
    endtask

    // ----------------------------------------------------------
    // One tick of the reference model
    // ----------------------------------------------------------
    task automatic evaluate();
        logic expReq;
        logic expWr;
        logic expRd;
        logic expCfg;
        int   done;
        // Changed byte is taken only when nothing is pending and the flash is free
        if (!opPend && !smpBusy && smpCmd != lastActed) begin
            lastActed = smpCmd;
            if (smpCmd == CmdReadCfg || smpCmd[7:1] == CmdWriteCfgPrefix) begin
                opPend   = 1'b1;
                pendAge  = 0;
                pendKind = (smpCmd == CmdReadCfg) ? OpRead : OpWrite;
                pendBit  = ~smpCmd[0];
            end
        end
        done = (runKind == OpWrite) ? WrDone : RdDone;
        if (running && n >= done) running = 1'b0;
        if (running) begin
            n++;
        end else if (promReq_i) begin
            // Rise of the request is tick 0
            if (!opPend) begin
                $display("Error at %0t ns: promReq_o rose with no command pending", $time);
                errCount_o++;
                testErrs++;
            end
            running = 1'b1;
            n       = 0;
            runKind = pendKind;
            runBit  = pendBit;
            opPend  = 1'b0;
            opsSeen_o++;
        end else if (opPend) begin
            pendAge++;
            if (pendAge > 3) begin
                $display("Command %h was never started on the flash (at %0t ns)",
                         lastActed, $time);
                errCount_o++;
                testErrs++;
                opPend = 1'b0;
            end
        end
        done   = (runKind == OpWrite) ? WrDone : RdDone;
        expReq = running && n < done;
        expWr  = running && runKind == OpWrite && n >= WrStart && n < WrEnd;
        if (runKind == OpWrite) begin
            expRd = running && n >= RbStart && n < RbEnd;
        end else begin
            expRd = running && n >= RdStart && n < RdEnd;
        end
        // Bit under write wins until the write is done
        expCfg = (running && runKind == OpWrite && n < WrDone) ? runBit : smpRdBit;
        compare("promReq_o", promReq_i, expReq);
        compare("wrPulse_o", wrPulse_i, expWr);
        compare("rdPulse_o", rdPulse_i, expRd);
        compare("cfgBit_o", cfgBit_i, expCfg);
    endtask

    // ----------------------------------------------------------
    // Sampling and per-test report
    // ----------------------------------------------------------
    always @(posedge CLK32768) begin
        if (!ResetN) begin
            lastActed = '0;
            opPend    = 1'b0;
            running   = 1'b0;
            runKind   = OpRead;
            pendKind  = OpRead;
            due       = 1'b0;
            n         = 0;
            curTest   = 0;
        end else begin
            // Outputs now hold what the previous tick produced
            if (due) evaluate();
            if (testNo_i != curTest) begin
                if (curTest > 0) begin
                    $display("Test %0d, cmd %h: %s", curTest, testCmd,
                             (testErrs == 0) ? "ok" : "FAIL");
                    if (testErrs != 0) testsFailed_o++;
                end
                curTest  = testNo_i;
                testCmd  = cmd_i;
                testErrs = 0;
            end
            due = tick_i;
            if (tick_i) begin
                smpCmd   = cmd_i;
                smpBusy  = promBusy_i;
                smpRdBit = cfgRdBit_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/psCfgTb.sv
// ----------------------------------------------------------
// Testbench for the power-supply configuration block
// Clock, reset, 1 ms tick, random host commands and flash
// busy periods, timeout and the closing report
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module psCfgTb
    import psCfgPkg::*;
();

    // Sequence timing as in the top level defaults
    localparam int WrStart = 2;
    localparam int WrEnd   = 6;
    localparam int RbStart = 8;
    localparam int RbEnd   = 9;
    localparam int WrDone  = 11;
    localparam int RdStart = 2;
    localparam int RdEnd   = 4;
    localparam int RdDone  = 6;

    localparam int NumCmds       = 60;
    // Each command gets at most 20 ticks of 4 clocks
    localparam int TimeoutCycles = NumCmds * 20 * 4 + 200;

    logic     CLK32768;
    logic     ResetN;
    logic     tick;
    cmdByte_t cmd;
    logic     promBusy;
    logic     cfgRdBit;
    logic     promReq;
    logic     rdPulse;
    logic     wrPulse;
    logic     cfgBit;

    logic [1:0] divCnt;
    cmdByte_t   prevCmd;
    int         seed;
    int         testNo;
    int         cycleCount;
    int         errCount;
    int         testsFailed;
    int         opsSeen;
    int         assertFails;

    psCfgTop psCfgTop_i (
        .CLK32768   (CLK32768),
        .ResetN     (ResetN),
        .tick_i     (tick),
        .cmd_i      (cmd),
        .promBusy_i (promBusy),
        .cfgRdBit_i (cfgRdBit),
        .promReq_o  (promReq),
        .rdPulse_o  (rdPulse),
        .wrPulse_o  (wrPulse),
        .cfgBit_o   (cfgBit)
    );

    psCfgChk #(
        .WrStart (WrStart),
        .WrEnd   (WrEnd),
        .RbStart (RbStart),
        .RbEnd   (RbEnd),
        .WrDone  (WrDone),
        .RdStart (RdStart),
        .RdEnd   (RdEnd),
        .RdDone  (RdDone)
    ) psCfgChk_i (
        .CLK32768      (CLK32768),
        .ResetN        (ResetN),
        .tick_i        (tick),
        .cmd_i         (cmd),
        .promBusy_i    (promBusy),
        .cfgRdBit_i    (cfgRdBit),
        .promReq_i     (promReq),
        .rdPulse_i     (rdPulse),
        .wrPulse_i     (wrPulse),
        .cfgBit_i      (cfgBit),
        .testNo_i      (testNo),
        .errCount_o    (errCount),
        .testsFailed_o (testsFailed),
        .opsSeen_o     (opsSeen)
    );

    assign assertFails = psCfgTop_i.psCfgTop_chk_i.failCount;

    always #50 CLK32768 = ~CLK32768;

    // One clock in four stands in for the 1 ms tick
    always @(posedge CLK32768) begin
        divCnt <= divCnt + 2'd1;
        tick   <= (divCnt == 2'd2);
    end

    always @(posedge CLK32768) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: run still going after %0d clock cycles", TimeoutCycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic waitTick();
        do @(posedge CLK32768); while (!tick);
    endtask

    // ----------------------------------------------------------
    // One host command held until the request falls or 20 ticks pass
    // ----------------------------------------------------------
    task automatic runStep(input int idx);
        cmdByte_t nextCmd;
        int       pick;
        int       busyTicks;
        int       t;
        logic     reqSeen;
        logic     fell;
        pick = {$random(seed)} % 10;
        if (pick < 3) nextCmd = CmdReadCfg;
        else if (pick < 5) nextCmd = {CmdWriteCfgPrefix, 1'b0};
        else if (pick < 7) nextCmd = {CmdWriteCfgPrefix, 1'b1};
        else if (pick < 9) nextCmd = prevCmd;
        else nextCmd = cmdByte_t'($random(seed));
        // Flash busy for a few ticks while the sequencer is idle
        if ({$random(seed)} % 4 == 0) busyTicks = 1 + {$random(seed)} % 5;
        else busyTicks = 0;
        cmd      <= nextCmd;
        promBusy <= (busyTicks != 0);
        testNo   <= idx;
        prevCmd  = nextCmd;
        t        = 0;
        reqSeen  = 1'b0;
        fell     = 1'b0;
        while (t < 20 && !fell) begin
            waitTick();
            t++;
            cfgRdBit <= 1'($random(seed));
            if (t == busyTicks) promBusy <= 1'b0;
            if (promReq) reqSeen = 1'b1;
            else if (reqSeen) fell = 1'b1;
        end
    endtask

    initial begin
        seed     = 66633;
        CLK32768 = 1'b0;
        ResetN   = 1'b0;
        tick     = 1'b0;
        cmd      = '0;
        promBusy = 1'b0;
        cfgRdBit = 1'b0;
        divCnt   = '0;
        prevCmd  = '0;
        testNo   = 0;
        repeat (10) @(posedge CLK32768);
        ResetN <= 1'b1;
        repeat (2) waitTick();
        for (int i = 1; i <= NumCmds; i++) begin
            runStep(i);
        end
        // Close the last test in the checker
        @(posedge CLK32768);
        testNo <= NumCmds + 1;
        repeat (4) @(posedge CLK32768);
        $display("Tests %0d, failed %0d, operations %0d, errors %0d, assertion failures %0d",
                 NumCmds, testsFailed, opsSeen, errCount, assertFails);
        if (errCount == 0 && testsFailed == 0 && assertFails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
logic/psCfgPkg.sv
logic/psCmdMonitor.sv
logic/psReqHolder.sv
logic/psPromSequencer.sv
logic/psCfgTop.sv
tests/psCfgTop_chk.sv
tests/psCfgChk.sv
tests/psCfgTb.sv

//--- Bender.yml
package:
  name: ps_cfg

sources:
  - files:
      - logic/psCfgPkg.sv
      - logic/psCmdMonitor.sv
      - logic/psReqHolder.sv
      - logic/psPromSequencer.sv
      - logic/psCfgTop.sv
  - target: test
    files:
      - tests/psCfgTop_chk.sv
      - tests/psCfgChk.sv
      - tests/psCfgTb.sv
